// ==== fetch_front.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/fetch_icache.sv
hdl/fetch_stage.sv
hdl/fetch_front_top.sv
sim/fetch_front_checker.sv
sim/fetch_front_tb.sv

// ==== hdl/fetch_defs.svh ====
// ====================================================================
// Widths, line shape, cache depth and reset address of the fetch
// front end. Included by the package and by every module using them
// ====================================================================

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Width of a byte address
`define FETCH_ADDR_W 32

// Width of one instruction word
`define FETCH_INSN_W 32

// Instruction words held in one fetch line
`define FETCH_SLOTS 4

// Bytes in one fetch line and the step of the program counter
`define FETCH_LINE_BYTES 16

// Cache index bits giving 16 lines
`define FETCH_IDX_W 4

// Width of the stream number that tags each fetch path
`define FETCH_STREAM_W 3

// Fetch address after reset
`define FETCH_RST_PC 32'h0000_0100

// No-operation word used to fill squashed groups
`define FETCH_NOP 32'h0000_0013

`endif

// ==== hdl/fetch_front_top.sv ====
// ====================================================================
// Fetch front end top level. Connects the address generator, the
// instruction cache and the fetch pipeline register
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

module fetch_front_top import fetch_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         fill_valid_i,
	input  cache_fill_t  fill_i,
	input  logic         inv_i,
	input  logic         redirect_i,
	input  fetch_addr_t  redirect_pc_i,
	input  logic         flush_i,
	input  logic         stall_i,
	output fetch_group_t group_o
);

	// Tagged address shared by the cache lookup and the fetch stage
	fetch_pc_t   fetch_pc;
	// Cache result for the current address
	fetch_line_t ic_line;
	logic        ic_hit;

	fetch_pc_gen fetch_pc_gen_i (
		.clk           (clk),
		.rst           (rst),
		.stall_i       (stall_i),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.pc_o          (fetch_pc)
	);

	// The cache keeps accepting fills while the front end is stalled
	fetch_icache fetch_icache_i (
		.clk          (clk),
		.rst          (rst),
		.fill_valid_i (fill_valid_i),
		.fill_i       (fill_i),
		.inv_i        (inv_i),
		.lookup_pc_i  (fetch_pc.pc),
		.line_o       (ic_line),
		.hit_o        (ic_hit)
	);

	fetch_stage fetch_stage_i (
		.clk        (clk),
		.rst        (rst),
		.stall_i    (stall_i),
		.flush_i    (flush_i),
		.redirect_i (redirect_i),
		.pc_i       (fetch_pc),
		.line_i     (ic_line),
		.hit_i      (ic_hit),
		.group_o    (group_o)
	);

endmodule

`default_nettype wire

// ==== hdl/fetch_icache.sv ====
// ====================================================================
// Direct-mapped instruction line store with tags and valid bits.
// Lookup is combinational and a fill is seen from the next cycle
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_icache import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        fill_valid_i,
	input  cache_fill_t fill_i,
	input  logic        inv_i,
	input  fetch_addr_t lookup_pc_i,
	output fetch_line_t line_o,
	output logic        hit_o
);

	// Byte offset bits inside a line
	localparam int OFF_W = $clog2(`FETCH_LINE_BYTES);
	// Tag covers every address bit above the index
	localparam int TAG_W = `FETCH_ADDR_W - `FETCH_IDX_W - OFF_W;
	localparam int LINES = 1 << `FETCH_IDX_W;

	// ==================================================================
	// Storage
	// ==================================================================

	fetch_line_t            line_mem [LINES];
	logic [TAG_W-1:0]       tag_mem [LINES];
	logic [LINES-1:0]       valid;

	logic [`FETCH_IDX_W-1:0] fill_idx;
	logic [TAG_W-1:0]        fill_tag;
	logic [`FETCH_IDX_W-1:0] look_idx;
	logic [TAG_W-1:0]        look_tag;

	// Split both addresses into index and tag
	always_comb begin
		fill_idx = fill_i.addr[OFF_W +: `FETCH_IDX_W];
		fill_tag = fill_i.addr[`FETCH_ADDR_W-1 -: TAG_W];
		look_idx = lookup_pc_i[OFF_W +: `FETCH_IDX_W];
		look_tag = lookup_pc_i[`FETCH_ADDR_W-1 -: TAG_W];
	end

	// Line data and tag are written together on every fill
	always_ff @(posedge clk) begin
		if (fill_valid_i) begin
			line_mem[fill_idx] <= fill_i.line;
			tag_mem[fill_idx] <= fill_tag;
		end
	end

	// Invalidate clears every entry first and a fill in the same cycle
	// then sets its own bit again, so the new line survives
	always_ff @(posedge clk) begin
		if (rst)
			valid <= '0;
		else begin
			if (inv_i)
				valid <= '0;
			if (fill_valid_i)
				valid[fill_idx] <= 1'b1;
		end
	end

	// ==================================================================
	// Lookup
	// ==================================================================

	// Zero-latency read of the indexed entry
	always_comb begin
		line_o = line_mem[look_idx];
		hit_o = valid[look_idx] && (tag_mem[look_idx] == look_tag);
	end

endmodule

`default_nettype wire

// ==== hdl/fetch_pc_gen.sv ====
// ====================================================================
// Fetch address generator. Steps one line per unstalled cycle and
// loads a line-aligned target with a new stream number on redirect
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_pc_gen import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall_i,
	input  logic        redirect_i,
	input  fetch_addr_t redirect_pc_i,
	output fetch_pc_t   pc_o
);

	// Mask that clears the byte offset inside a line
	localparam fetch_addr_t LINE_MASK = ~fetch_addr_t'(`FETCH_LINE_BYTES - 1);

	fetch_addr_t next_seq_pc;
	fetch_addr_t aligned_target;

	// Next sequential line address
	always_comb
		next_seq_pc = pc_o.pc + fetch_addr_t'(`FETCH_LINE_BYTES);

	// Redirect targets may point inside a line so drop the offset
	always_comb
		aligned_target = redirect_pc_i & LINE_MASK;

	// ==================================================================
	// Address register
	// ==================================================================

	// Redirect wins over stall so a mispredict is never held back
	// The stream number wraps modulo 8 through its natural width
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_o.pc <= `FETCH_RST_PC;
			pc_o.stream <= '0;
		end
		else if (redirect_i) begin
			pc_o.pc <= aligned_target;
			pc_o.stream <= pc_o.stream + stream_t'(1);
		end
		else if (!stall_i) begin
			// Stream stays the same on the sequential path
			pc_o.pc <= next_seq_pc;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
// ====================================================================
// Shared types of the fetch front end used by the RTL and testbench
// ====================================================================

`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

	// Byte address of an instruction or a fetch line
	typedef logic [`FETCH_ADDR_W-1:0] fetch_addr_t;

	// One instruction word
	typedef logic [`FETCH_INSN_W-1:0] insn_t;

	// A whole fetch line with slot 0 in the low bits
	typedef insn_t [`FETCH_SLOTS-1:0] fetch_line_t;

	// Stream number that changes on every redirect
	typedef logic [`FETCH_STREAM_W-1:0] stream_t;

	// Tagged fetch address as produced by the address generator
	typedef struct packed {
		fetch_addr_t pc;
		stream_t     stream;
	} fetch_pc_t;

	// One line write into the instruction cache
	typedef struct packed {
		fetch_addr_t addr;
		fetch_line_t line;
	} cache_fill_t;

	// Registered fetch group handed on to decode
	typedef struct packed {
		fetch_addr_t              pc0;
		fetch_addr_t              pc1;
		fetch_addr_t              pc2;
		fetch_addr_t              pc3;
		stream_t                  stream;
		fetch_line_t              line;
		logic [`FETCH_SLOTS-1:0]  slot_valid;
		logic                     hit;
	} fetch_group_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
// ====================================================================
// Fetch pipeline register. Builds the group of slot addresses, line,
// stream and valid bits and squashes it on miss, flush or redirect
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_stage import fetch_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         stall_i,
	input  logic         flush_i,
	input  logic         redirect_i,
	input  fetch_pc_t    pc_i,
	input  fetch_line_t  line_i,
	input  logic         hit_i,
	output fetch_group_t group_o
);

	// Bytes taken by one instruction word
	localparam int INSN_BYTES = `FETCH_INSN_W / 8;

	// Line of no-operation words that replaces a squashed fetch
	localparam fetch_line_t NOP_LINE = {`FETCH_SLOTS{insn_t'(`FETCH_NOP)}};

	// Address of a given slot within the line starting at base
	function automatic fetch_addr_t slot_pc(input fetch_addr_t base, input int slot);
		slot_pc = base + fetch_addr_t'(slot * INSN_BYTES);
	endfunction

	logic         load;
	logic         squash;
	fetch_group_t next_group;
	fetch_group_t rst_group;

	// ==================================================================
	// Group construction
	// ==================================================================

	// The register moves when not stalled, and a redirect or flush
	// still gets through a stall so the wrong path is dropped at once
	always_comb begin
		load = !stall_i || flush_i || redirect_i;
		squash = !hit_i || flush_i || redirect_i;
	end

	// Next group from the presented address and the cache lookup
	always_comb begin
		next_group.pc0 = slot_pc(pc_i.pc, 0);
		next_group.pc1 = slot_pc(pc_i.pc, 1);
		next_group.pc2 = slot_pc(pc_i.pc, 2);
		next_group.pc3 = slot_pc(pc_i.pc, 3);
		next_group.stream = pc_i.stream;
		next_group.hit = hit_i;
		if (squash) begin
			next_group.line = NOP_LINE;
			next_group.slot_valid = '0;
		end
		else begin
			next_group.line = line_i;
			next_group.slot_valid = '1;
		end
	end

	// Empty group at the reset address
	always_comb begin
		rst_group.pc0 = slot_pc(`FETCH_RST_PC, 0);
		rst_group.pc1 = slot_pc(`FETCH_RST_PC, 1);
		rst_group.pc2 = slot_pc(`FETCH_RST_PC, 2);
		rst_group.pc3 = slot_pc(`FETCH_RST_PC, 3);
		rst_group.stream = '0;
		rst_group.line = NOP_LINE;
		rst_group.slot_valid = '0;
		rst_group.hit = 1'b0;
	end

	// ==================================================================
	// Pipeline register
	// ==================================================================

	// Holds its value under stall so no group is lost or repeated
	always_ff @(posedge clk) begin
		if (rst)
			group_o <= rst_group;
		else if (load)
			group_o <= next_group;
	end

endmodule

`default_nettype wire

// ==== sim/fetch_front_checker.sv ====
// ====================================================================
// Reference model and scoreboard of the fetch front end. Mirrors the
// line store and fetch address and compares group_o on every edge
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_front_checker import fetch_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         fill_valid_i,
	input  cache_fill_t  fill_i,
	input  logic         inv_i,
	input  logic         redirect_i,
	input  fetch_addr_t  redirect_pc_i,
	input  logic         flush_i,
	input  logic         stall_i,
	input  fetch_group_t group_i,
	input  int           row_i,
	output int           errors_o,
	output int           checks_o
);

	localparam int INSN_BYTES = `FETCH_INSN_W / 8;
	localparam int LINES = 1 << `FETCH_IDX_W;

	// The mirror keeps the whole line address rather than a tag
	fetch_line_t      mem_line [LINES];
	fetch_addr_t      mem_addr [LINES];
	logic [LINES-1:0] mem_valid;

	// Next expected address and the group expected on the output
	fetch_addr_t  exp_pc;
	stream_t      exp_stream;
	fetch_group_t exp_group;
	// Table row whose inputs built exp_group, with its own counts
	int           grp_row;
	int           row_checks;
	int           row_errors;

	// Group as the fetch rules describe it for a line address
	function automatic fetch_group_t make_group(input fetch_addr_t pc, input stream_t s,
			input logic hit, input logic keep, input fetch_line_t line);
		fetch_group_t g;
		g.pc0 = pc;
		g.pc1 = pc + INSN_BYTES;
		g.pc2 = pc + 2 * INSN_BYTES;
		g.pc3 = pc + 3 * INSN_BYTES;
		g.stream = s;
		g.hit = hit;
		g.line = keep ? line : {`FETCH_SLOTS{insn_t'(`FETCH_NOP)}};
		g.slot_valid = {`FETCH_SLOTS{keep}};
		return g;
	endfunction

	task automatic check_field(input string name, input logic [127:0] exp_v,
			input logic [127:0] act_v);
		checks_o++;
		row_checks++;
		if (act_v !== exp_v) begin
			errors_o++;
			row_errors++;
			$display("** Error at time %0t: %s expected %0h actual %0h",
				$time, name, exp_v, act_v);
		end
	endtask

	// ==================================================================
	// Model step and comparison
	// ==================================================================

	// Everything is read as it was just before the edge
	always @(posedge clk) begin
		int   idx;
		logic hit;
		if (rst) begin
			mem_valid = '0;
			exp_pc = `FETCH_RST_PC;
			exp_stream = '0;
			exp_group = make_group(`FETCH_RST_PC, '0, 1'b0, 1'b0, '0);
			grp_row = -1;
			row_checks = 0;
			row_errors = 0;
			errors_o = 0;
			checks_o = 0;
		end
		else begin
			check_field("pc0..pc3", {exp_group.pc0, exp_group.pc1, exp_group.pc2,
				exp_group.pc3}, {group_i.pc0, group_i.pc1, group_i.pc2, group_i.pc3});
			check_field("stream", exp_group.stream, group_i.stream);
			check_field("line", exp_group.line, group_i.line);
			check_field("slot_valid", exp_group.slot_valid, group_i.slot_valid);
			check_field("hit", exp_group.hit, group_i.hit);
			// A new row index means the previous row has delivered its last group
			if (row_i != grp_row) begin
				if (grp_row >= 0)
					$display("Row %0d done: %0d checks, %0d errors",
						grp_row, row_checks, row_errors);
				grp_row = row_i;
				row_checks = 0;
				row_errors = 0;
			end
			idx = (exp_pc / `FETCH_LINE_BYTES) % LINES;
			hit = mem_valid[idx] && (mem_addr[idx] == exp_pc);
			// Redirect and flush reach the register through a stall
			if (!stall_i || flush_i || redirect_i)
				exp_group = make_group(exp_pc, exp_stream, hit,
					hit && !flush_i && !redirect_i, mem_line[idx]);
			// Invalidate first so a fill in the same cycle stays valid
			if (inv_i)
				mem_valid = '0;
			if (fill_valid_i) begin
				idx = (fill_i.addr / `FETCH_LINE_BYTES) % LINES;
				mem_line[idx] = fill_i.line;
				mem_addr[idx] = fill_i.addr - fill_i.addr % `FETCH_LINE_BYTES;
				mem_valid[idx] = 1'b1;
			end
			if (redirect_i) begin
				exp_pc = redirect_pc_i - redirect_pc_i % `FETCH_LINE_BYTES;
				exp_stream = exp_stream + 1'b1;
			end
			else if (!stall_i)
				exp_pc = exp_pc + `FETCH_LINE_BYTES;
		end
	end

endmodule

`default_nettype wire

// ==== sim/fetch_front_tb.sv ====
// ====================================================================
// Testbench of the fetch front end. Applies a stimulus table row by
// row and leaves the comparing to the checker instance
// ====================================================================

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_front_tb import fetch_pkg::*; ();

	// One table row, applied for hold cycles
	typedef struct packed {
		logic        fill;
		fetch_addr_t fill_addr;
		logic        inv;
		logic        redir;
		fetch_addr_t target;
		logic        flush;
		logic        stall;
		logic [7:0]  hold;
	} stim_row_t;

	localparam int ROWS = 18;

	// A fill row writes successive lines from fill_addr, one per cycle
	localparam stim_row_t STIM [ROWS] = '{
		// fill  fill_addr   inv   redir  target      flush stall hold
		'{1'b0, 32'h0000, 1'b0, 1'b0, 32'h0000, 1'b0, 1'b0, 8'd2},
		'{1'b1, 32'h0100, 1'b0, 1'b0, 32'h0000, 1'b0, 1'b1, 8'd4},
		'{1'b0, 32'h0000, 1'b0, 1'b1, 32'h0104, 1'b0, 1'b0, 8'd1},
		'{1'b0, 32'h0000, 1'b0, 1'b0, 32'h0000, 1'b0, 1'b0, 8'd4},
		'{1'b0, 32'h0000, 1'b0, 1'b0, 32'h0000, 1'b0, 1'b1, 8'd5},
		'{1'b0, 32'h0000, 1'b0, 1'b0, 32'h0000, 1'b0, 1'b0, 8'd2},
		'{1'b0, 32'h0000, 1'b0, 1'b1, 32'h0128, 1'b0, 1'b0, 8'd1},
		'{1'b0, 32'h0000, 1'b0, 1'b0, 32'h0000, 1'b1, 1'b0, 8'd1},
		'{1'b0, 32'h0000, 1'b0, 1'b0, 32'h0000, 1'b0, 1'b0, 8'd2},
		'{1'b0, 32'h0000, 1'b1, 1'b1, 32'h0100, 1'b0, 1'b0, 8'd1},
		'{1'b0, 32'h0000, 1'b0, 1'b0, 32'h0000, 1'b0, 1'b0, 8'd2},
		'{1'b1, 32'h1100, 1'b0, 1'b1, 32'h0100, 1'b0, 1'b0, 8'd1},
		'{1'b0, 32'h0000, 1'b0, 1'b0, 32'h0000, 1'b0, 1'b0, 8'd1},
		'{1'b1, 32'h0100, 1'b1, 1'b1, 32'h0100, 1'b0, 1'b0, 8'd1},
		'{1'b0, 32'h0000, 1'b0, 1'b0, 32'h0000, 1'b0, 1'b0, 8'd2},
		'{1'b0, 32'h0000, 1'b0, 1'b1, 32'h0200, 1'b0, 1'b0, 8'd8},
		'{1'b0, 32'h0000, 1'b0, 1'b1, 32'h030c, 1'b0, 1'b1, 8'd1},
		'{1'b0, 32'h0000, 1'b0, 1'b0, 32'h0000, 1'b0, 1'b0, 8'd3}
	};

	logic         clk = 1'b0;
	logic         rst;
	logic         fill_valid;
	cache_fill_t  fill;
	logic         inv;
	logic         redirect;
	fetch_addr_t  redirect_pc;
	logic         flush;
	logic         stall;
	fetch_group_t group;
	int           row;
	int           errors;
	int           checks;
	int           cycles = 0;
	int           cycle_limit;
	integer       seed;

	always #2 clk = ~clk;

	fetch_front_top fetch_front_top_i (
		.clk (clk), .rst (rst), .fill_valid_i (fill_valid), .fill_i (fill),
		.inv_i (inv), .redirect_i (redirect), .redirect_pc_i (redirect_pc),
		.flush_i (flush), .stall_i (stall), .group_o (group)
	);

	fetch_front_checker fetch_front_checker_i (
		.clk (clk), .rst (rst), .fill_valid_i (fill_valid), .fill_i (fill),
		.inv_i (inv), .redirect_i (redirect), .redirect_pc_i (redirect_pc),
		.flush_i (flush), .stall_i (stall), .group_i (group), .row_i (row),
		.errors_o (errors), .checks_o (checks)
	);

	task automatic drive_row(input int r, input int c);
		fill_valid <= STIM[r].fill;
		fill.addr <= STIM[r].fill_addr + fetch_addr_t'(c * `FETCH_LINE_BYTES);
		fill.line <= {$random(seed), $random(seed), $random(seed), $random(seed)};
		inv <= STIM[r].inv;
		redirect <= STIM[r].redir;
		redirect_pc <= STIM[r].target;
		flush <= STIM[r].flush;
		stall <= STIM[r].stall;
		row <= r;
	endtask

	task automatic drive_idle(input int r);
		fill_valid <= 1'b0;
		fill <= '0;
		inv <= 1'b0;
		redirect <= 1'b0;
		redirect_pc <= '0;
		flush <= 1'b0;
		stall <= 1'b0;
		row <= r;
	endtask

	// ==================================================================
	// Stimulus and end of run
	// ==================================================================

	initial begin
		int total;
		total = 0;
		seed = 32'h489c_d6a3;
		rst <= 1'b1;
		drive_idle(-1);
		for (int r = 0; r < ROWS; r++)
			total += STIM[r].hold;
		cycle_limit = 16 + total + 20;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < STIM[r].hold; c++) begin
				drive_row(r, c);
				@(posedge clk);
			end
		end
		// Row index past the table lets the checker close the last row
		drive_idle(ROWS);
		repeat (3) @(posedge clk);
		// Counts are read between edges once the last group is compared
		@(negedge clk);
		$display("Rows %0d, checks %0d, errors %0d", ROWS, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run went past %0d cycles", cycle_limit);
			$display("Finished with errors");
			$finish;
		end
	end

endmodule

`default_nettype wire
